/* cpu_core.f */
cpu_pkg.sv
program_counter.sv
lifo_stack.sv
alu.sv
instr_fetch.sv
instr_decoder.sv
execute_unit.sv
cpu_core.sv
tb_cpu_core.sv

/* Makefile */
# Verilator simulation of the processor core

VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log shows the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_cpu_core.sv */
// Testbench for the processor core
// Random programs from an LFSR, run on the DUT and on a sequential ISA model

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int IW    = NBOPCO + NBOPER;
	localparam int ISIZE = 2 ** MINSTW;
	localparam int MSIZE = 2 ** MDATAW;
	localparam int NIO   = 64;

	logic              clk;
	logic              rst;
	logic [IW-1:0]     instr = '0;
	logic [MINSTW-1:0] instr_addr;
	logic [MDATAW-1:0] mem_addr_rd;
	logic [NUBITS-1:0] mem_data_rd = '0;
	mem_wr_t           mem_wr;
	logic [NUBITS-1:0] io_in = '0;
	logic              req_in;
	logic [NBIO-1:0]   addr_in;
	io_out_t           io_out;

	logic [IW-1:0]     imem [ISIZE];
	logic [NUBITS-1:0] dmem [MSIZE];
	logic [NUBITS-1:0] mmem [MSIZE];
	logic [NUBITS-1:0] io_vals [NIO];
	logic [MINSTW-1:0] ia_q;
	logic [MDATAW-1:0] rd_q;
	logic              req_q;
	int                io_idx;
	logic [31:0]       got_wr[$];
	logic [31:0]       got_out[$];
	logic [31:0]       got_in[$];
	logic [31:0]       exp_wr[$];
	logic [31:0]       exp_out[$];
	logic [31:0]       exp_in[$];
	logic [31:0]       lfsr;
	int                plen;
	int                errors;
	int                err_base;
	int                tests;
	int                fails;
	int                halt;

	cpu_core #(
		.NBOPCO(NBOPCO), .NBOPER(NBOPER), .MINSTW(MINSTW), .MDATAW(MDATAW),
		.NUBITS(NUBITS), .SDEPTH(SDEPTH), .DDEPTH(DDEPTH), .NBIO(NBIO)
	) dut (
		.clk(clk), .rst(rst), .instr(instr), .instr_addr(instr_addr),
		.mem_addr_rd(mem_addr_rd), .mem_data_rd(mem_data_rd), .mem_wr(mem_wr),
		.io_in(io_in), .req_in(req_in), .addr_in(addr_in), .io_out(io_out)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Environment ------------------------------
	function automatic logic [NUBITS-1:0] fill(int a);
		return NUBITS'(a * 59) ^ NUBITS'(a << 7) ^ 16'h5a5a;
	endfunction

	// Write-first data memory, write, port and input request monitors
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MSIZE; i++)
				dmem[i] <= fill(i);
			got_wr.delete();
			got_out.delete();
			got_in.delete();
		end else begin
			if (mem_wr.en) begin
				dmem[mem_wr.addr] <= mem_wr.data;
				got_wr.push_back(32'({mem_wr.addr, mem_wr.data}));
			end
			if (io_out.en)
				got_out.push_back(32'({io_out.addr, io_out.data}));
			if (req_in)
				got_in.push_back(32'(addr_in));
		end
		ia_q  <= instr_addr;
		rd_q  <= mem_addr_rd;
		req_q <= req_in;
	end

	// Read data goes out on the falling edge
	always @(negedge clk) begin
		instr       <= imem[ia_q];
		mem_data_rd <= dmem[rd_q];
		if (rst) begin
			io_idx <= 0;
		end else if (req_q) begin
			io_in  <= io_vals[io_idx];
			io_idx <= io_idx + 1;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_step();
		logic b;
		b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], b};
		return b;
	endfunction

	function automatic int rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return int'(v);
	endfunction

	// Program building -------------------------
	task automatic clear_prog();
		for (int i = 0; i < ISIZE; i++)
			imem[i] = '0;
		plen = 0;
	endtask

	task automatic emit(opcode_e op, int opd);
		imem[plen] = {op, NBOPER'(opd)};
		plen++;
	endtask

	task automatic gen_alu(output int h);
		opcode_e ops [12] = '{OP_LOD, OP_SET, OP_ADD, OP_SUB, OP_AND, OP_ORR,
			OP_XOR, OP_SHL, OP_SHR, OP_LES, OP_EQU, OP_INV};
		clear_prog();
		for (int i = 0; i < 40; i++)
			emit(ops[rand_bits(4) % 12], rand_bits(4));
		h = plen;
		emit(OP_JMP, h);
	endtask

	task automatic gen_stack(output int h);
		int depth;
		int r;
		clear_prog();
		depth = 0;
		for (int i = 0; i < 40; i++) begin
			r = rand_bits(2);
			if (r == 0) begin
				emit(OP_LOD, rand_bits(4));
			end else if (r == 1) begin
				emit(OP_ADD, rand_bits(4));
			end else if ((r == 2 && depth < DDEPTH) || depth == 0) begin
				emit(OP_PSH, 0);
				depth++;
			end else begin
				emit(OP_POP, 0);
				emit(OP_SET, rand_bits(4));
				depth--;
			end
		end
		h = plen;
		emit(OP_JMP, h);
	endtask

	// Blocks of three words, marker address 32 plus the block number
	task automatic gen_branch(output int h);
		int t;
		clear_prog();
		for (int b = 0; b < 12; b++) begin
			emit(OP_LOD, 16 + rand_bits(4));
			emit(OP_SET, 32 + b);
			t = b + 1 + rand_bits(2) % 3;
			if (t > 12)
				t = 12;
			emit(rand_bits(1) != 0 ? OP_JIZ : OP_JMP, 3 * t);
		end
		h = plen;
		emit(OP_JMP, h);
	endtask

	task automatic gen_calls(output int h);
		clear_prog();
		emit(OP_CAL, 16);
		emit(OP_SET, 63);
		emit(OP_JMP, 2);
		h = 2;
		for (int k = 1; k <= SDEPTH; k++) begin
			plen = 16 * k;
			emit(OP_LOD, rand_bits(4));
			emit(OP_SET, 64 + k);
			if (k < SDEPTH)
				emit(OP_CAL, 16 * (k + 1));
			emit(OP_SET, 80 + k);
			emit(OP_RET, 0);
		end
	endtask

	task automatic gen_ports(output int h);
		opcode_e ops [4] = '{OP_INN, OP_OUT, OP_ADD, OP_SET};
		clear_prog();
		for (int i = 0; i < 40; i++)
			emit(ops[rand_bits(2)], rand_bits(4));
		h = plen;
		emit(OP_JMP, h);
	endtask

	// ISA model ---------------------------------
	task automatic run_model(int h);
		logic [NUBITS-1:0] acc;
		logic [NUBITS-1:0] opv;
		logic [NBOPER-1:0] opd;
		logic [MDATAW-1:0] a;
		opcode_e           op;
		logic [MINSTW-1:0] cst[$];
		logic [NUBITS-1:0] dst[$];
		int                pc;
		int                steps;
		int                k;
		for (int i = 0; i < MSIZE; i++)
			mmem[i] = fill(i);
		exp_wr.delete();
		exp_out.delete();
		exp_in.delete();
		acc   = '0;
		pc    = 0;
		steps = 0;
		k     = 0;
		while (pc != h && steps < 10000) begin
			op  = opcode_e'(imem[pc][IW-1:NBOPER]);
			opd = imem[pc][NBOPER-1:0];
			a   = opd[MDATAW-1:0];
			opv = mmem[a];
			pc++;
			steps++;
			case (op)
				OP_LOD: acc = opv;
				OP_SET: begin
					mmem[a] = acc;
					exp_wr.push_back(32'({a, acc}));
				end
				OP_PSH: dst.push_back(acc);
				OP_POP: acc = dst.pop_back();
				OP_INN: begin
					exp_in.push_back(32'(opd[NBIO-1:0]));
					acc = io_vals[k];
					k++;
				end
				OP_OUT: exp_out.push_back(32'({opd[NBIO-1:0], acc}));
				OP_ADD: acc = acc + opv;
				OP_SUB: acc = acc - opv;
				OP_AND: acc = acc & opv;
				OP_ORR: acc = acc | opv;
				OP_XOR: acc = acc ^ opv;
				OP_SHL: acc = acc << opv[3:0];
				OP_SHR: acc = acc >> opv[3:0];
				OP_LES: acc = ($signed(acc) < $signed(opv)) ? NUBITS'(1) : '0;
				OP_EQU: acc = (acc == opv) ? NUBITS'(1) : '0;
				OP_INV: acc = ~acc;
				OP_JMP: pc = int'(opd[MINSTW-1:0]);
				OP_JIZ: if (!acc[0]) pc = int'(opd[MINSTW-1:0]);
				OP_CAL: begin
					cst.push_back(MINSTW'(pc));
					pc = int'(opd[MINSTW-1:0]);
				end
				OP_RET: pc = int'(cst.pop_back());
				default: ;
			endcase
		end
		if (pc != h) begin
			$display("Model program never reached its final jump");
			errors++;
		end
	endtask

	// Checks ------------------------------------
	task automatic wait_halt(int h);
		int n;
		int stable;
		n      = 0;
		stable = 0;
		while (stable < 3 && n < 4000) begin
			@(negedge clk);
			#1;
			n++;
			stable = (instr_addr == MINSTW'(h)) ? stable + 1 : 0;
		end
		if (stable < 3) begin
			$display("Timeout: DUT did not settle on the final jump at %0d", h);
			errors++;
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic check_queue(string what, input logic [31:0] got[$],
			input logic [31:0] exp[$]);
		assert (got.size() == exp.size()) else begin
			$display("Mismatch at %0t: %s count %0d, expected %0d",
				$time, what, got.size(), exp.size());
			errors++;
		end
		for (int i = 0; i < got.size() && i < exp.size(); i++)
			assert (got[i] == exp[i]) else begin
				$display("Mismatch at %0t: %s #%0d is %h, expected %h",
					$time, what, i, got[i], exp[i]);
				errors++;
			end
	endtask

	task automatic begin_test();
		@(negedge clk);
		rst      = 1'b1;
		err_base = errors;
	endtask

	task automatic end_reset();
		repeat (3) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic finish_test(string name, int h);
		run_model(h);
		wait_halt(h);
		check_queue("memory write", got_wr, exp_wr);
		check_queue("port output", got_out, exp_out);
		check_queue("port input address", got_in, exp_in);
		for (int i = 0; i < MSIZE; i++)
			assert (dmem[i] === mmem[i]) else begin
				$display("Mismatch at %0t: final memory[%0d] is %h, expected %h",
					$time, i, dmem[i], mmem[i]);
				errors++;
			end
		tests++;
		if (errors == err_base) begin
			$display("test %s: passed", name);
		end else begin
			fails++;
			$display("test %s: failed with %0d errors", name, errors - err_base);
		end
	endtask

	task automatic check_idle(logic [MINSTW-1:0] addr);
		assert (!mem_wr.en && !io_out.en && !req_in && instr_addr == addr) else begin
			$display("Mismatch at %0t: after reset addr %0d wr %b out %b req %b",
				$time, instr_addr, mem_wr.en, io_out.en, req_in);
			errors++;
		end
	endtask

	// Sequence ----------------------------------
	initial begin
		rst      = 1'b1;
		lfsr     = 32'd73771;
		errors   = 0;
		err_base = 0;
		tests    = 0;
		fails    = 0;
		for (int i = 0; i < NIO; i++)
			io_vals[i] = NUBITS'(rand_bits(NUBITS));

		// Reset values, then the first address step
		// A store first shows up if the reset-time word gets decoded
		clear_prog();
		emit(OP_SET, 5);
		emit(OP_NOP, 0);
		emit(OP_JMP, 2);
		repeat (3) begin
			@(posedge clk);
			#1;
			check_idle('0);
		end
		@(negedge clk);
		rst = 1'b0;
		#1;
		check_idle('0);
		@(negedge clk);
		#1;
		check_idle(MINSTW'(1));
		finish_test("reset", 2);

		begin_test();
		gen_alu(halt);
		end_reset();
		finish_test("alu_memory", halt);

		begin_test();
		gen_stack(halt);
		end_reset();
		finish_test("data_stack", halt);

		begin_test();
		gen_branch(halt);
		end_reset();
		finish_test("branches", halt);

		begin_test();
		gen_calls(halt);
		end_reset();
		finish_test("calls", halt);

		begin_test();
		gen_ports(halt);
		end_reset();
		finish_test("ports", halt);

		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests, tests - fails, fails, errors);
		if (fails == 0 && errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* cpu_core.sv */
// Processor core top level
// Two stages, fetch/decode then execute, around external
// instruction memory, data memory and I/O ports

module cpu_core #(
	parameter int NBOPCO = cpu_pkg::NBOPCO,
	parameter int NBOPER = cpu_pkg::NBOPER,
	parameter int MINSTW = cpu_pkg::MINSTW,
	parameter int MDATAW = cpu_pkg::MDATAW,
	parameter int NUBITS = cpu_pkg::NUBITS,
	parameter int SDEPTH = cpu_pkg::SDEPTH,
	parameter int DDEPTH = cpu_pkg::DDEPTH,
	parameter int NBIO   = cpu_pkg::NBIO
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [NBOPCO+NBOPER-1:0] instr,
	output logic [MINSTW-1:0]        instr_addr,
	output logic [MDATAW-1:0]        mem_addr_rd,
	input  logic [NUBITS-1:0]        mem_data_rd,
	output cpu_pkg::mem_wr_t         mem_wr,
	input  logic [NUBITS-1:0]        io_in,
	output logic                     req_in,
	output logic [NBIO-1:0]          addr_in,
	output cpu_pkg::io_out_t         io_out
);
	import cpu_pkg::*;

	opcode_e           opcode;
	logic [NBOPER-1:0] operand;
	exec_ctrl_t        ctrl;
	logic              acc_lsb;

	instr_fetch #(
		.NBOPCO(NBOPCO),
		.NBOPER(NBOPER),
		.MINSTW(MINSTW),
		.SDEPTH(SDEPTH)
	) u_fetch (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.acc_lsb   (acc_lsb),
		.instr_addr(instr_addr),
		.opcode    (opcode),
		.operand   (operand)
	);

	instr_decoder #(
		.NBOPER(NBOPER),
		.MDATAW(MDATAW),
		.NBIO  (NBIO)
	) u_decoder (
		.clk        (clk),
		.rst        (rst),
		.opcode     (opcode),
		.operand    (operand),
		.ctrl       (ctrl),
		.mem_addr_rd(mem_addr_rd),
		.req_in     (req_in),
		.addr_in    (addr_in)
	);

	execute_unit #(
		.NUBITS(NUBITS),
		.MDATAW(MDATAW),
		.NBIO  (NBIO),
		.DDEPTH(DDEPTH)
	) u_execute (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.mem_data_rd(mem_data_rd),
		.io_in      (io_in),
		.mem_wr     (mem_wr),
		.io_out     (io_out),
		.acc_lsb    (acc_lsb)
	);

endmodule

/* execute_unit.sv */
// Execute stage
// Operand select, ALU, accumulator, data stack, memory write and
// the registered output port

module execute_unit #(
	parameter int NUBITS = cpu_pkg::NUBITS,
	parameter int MDATAW = cpu_pkg::MDATAW,
	parameter int NBIO   = cpu_pkg::NBIO,
	parameter int DDEPTH = cpu_pkg::DDEPTH
) (
	input  logic                clk,
	input  logic                rst,
	input  cpu_pkg::exec_ctrl_t ctrl,
	input  logic [NUBITS-1:0]   mem_data_rd,
	input  logic [NUBITS-1:0]   io_in,
	output cpu_pkg::mem_wr_t    mem_wr,
	output cpu_pkg::io_out_t    io_out,
	output logic                acc_lsb
);
	import cpu_pkg::*;

	logic [NUBITS-1:0] acc;
	logic [NUBITS-1:0] in1;
	logic [NUBITS-1:0] stack_top;
	logic [NUBITS-1:0] alu_out;
	logic              out_en_q;
	logic [NBIO-1:0]   out_addr_q;
	logic [NUBITS-1:0] out_data_q;

	// Operand select -----------------------------
	always_comb begin
		case (ctrl.src)
			SRC_STACK: in1 = stack_top;
			SRC_IO:    in1 = io_in;
			default:   in1 = mem_data_rd;
		endcase
	end

	alu #(
		.NUBITS(NUBITS)
	) u_alu (
		.op    (ctrl.alu_op),
		.in1   (in1),
		.acc   (acc),
		.result(alu_out)
	);

	// JIZ in decode sees the value this instruction leaves behind
	assign acc_lsb = alu_out[0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= alu_out;
		end
	end

	lifo_stack #(
		.WIDTH(NUBITS),
		.DEPTH(DDEPTH)
	) u_data_stack (
		.clk (clk),
		.rst (rst),
		.push(ctrl.push),
		.pop (ctrl.pop),
		.din (acc),
		.top (stack_top)
	);

	// Memory and port writes ---------------------
	assign mem_wr = '{en: ctrl.mem_we, addr: ctrl.addr[MDATAW-1:0], data: acc};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_en_q <= 1'b0;
		end else begin
			out_en_q <= ctrl.out_en;
		end
	end

	always_ff @(posedge clk) begin
		out_addr_q <= ctrl.addr[NBIO-1:0];
		out_data_q <= acc;
	end

	assign io_out = '{en: out_en_q, addr: out_addr_q, data: out_data_q};

endmodule

/* instr_decoder.sv */
// Instruction decoder
// Maps the opcode to execute controls, issues the memory read and
// input request, and holds the decode-to-execute register

module instr_decoder #(
	parameter int NBOPER = cpu_pkg::NBOPER,
	parameter int MDATAW = cpu_pkg::MDATAW,
	parameter int NBIO   = cpu_pkg::NBIO
) (
	input  logic                clk,
	input  logic                rst,
	input  cpu_pkg::opcode_e    opcode,
	input  logic [NBOPER-1:0]   operand,
	output cpu_pkg::exec_ctrl_t ctrl,
	output logic [MDATAW-1:0]   mem_addr_rd,
	output logic                req_in,
	output logic [NBIO-1:0]     addr_in
);
	import cpu_pkg::*;

	exec_ctrl_t next_ctrl;

	// Read side goes out during decode, data lands in execute
	assign mem_addr_rd = operand[MDATAW-1:0];
	assign req_in      = (opcode == OP_INN);
	assign addr_in     = operand[NBIO-1:0];

	always_comb begin
		next_ctrl        = '0;
		next_ctrl.alu_op = ALU_PASS_ACC;
		next_ctrl.src    = SRC_MEM;
		next_ctrl.addr   = operand;
		case (opcode)
			OP_LOD: next_ctrl.alu_op = ALU_PASS_IN;
			OP_SET: next_ctrl.mem_we = 1'b1;
			OP_PSH: next_ctrl.push   = 1'b1;
			OP_POP: begin
				next_ctrl.alu_op = ALU_PASS_IN;
				next_ctrl.src    = SRC_STACK;
				next_ctrl.pop    = 1'b1;
			end
			OP_INN: begin
				next_ctrl.alu_op = ALU_PASS_IN;
				next_ctrl.src    = SRC_IO;
			end
			OP_OUT: next_ctrl.out_en = 1'b1;
			OP_ADD: next_ctrl.alu_op = ALU_ADD;
			OP_SUB: next_ctrl.alu_op = ALU_SUB;
			OP_AND: next_ctrl.alu_op = ALU_AND;
			OP_ORR: next_ctrl.alu_op = ALU_OR;
			OP_XOR: next_ctrl.alu_op = ALU_XOR;
			OP_SHL: next_ctrl.alu_op = ALU_SHL;
			OP_SHR: next_ctrl.alu_op = ALU_SHR;
			OP_LES: next_ctrl.alu_op = ALU_LES;
			OP_EQU: next_ctrl.alu_op = ALU_EQU;
			OP_INV: next_ctrl.alu_op = ALU_NOT;
			// Branches, NOP and unused codes leave the accumulator alone
			default: next_ctrl.alu_op = ALU_PASS_ACC;
		endcase
	end

	// All-zero controls are a NOP
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl <= '0;
		end else begin
			ctrl <= next_ctrl;
		end
	end

endmodule

/* instr_fetch.sv */
// Instruction fetch
// Picks the next instruction address from the counter, a branch
// target or the call stack, and splits the instruction word

module instr_fetch #(
	parameter int NBOPCO = cpu_pkg::NBOPCO,
	parameter int NBOPER = cpu_pkg::NBOPER,
	parameter int MINSTW = cpu_pkg::MINSTW,
	parameter int SDEPTH = cpu_pkg::SDEPTH
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [NBOPCO+NBOPER-1:0] instr,
	input  logic                     acc_lsb,
	output logic [MINSTW-1:0]        instr_addr,
	output cpu_pkg::opcode_e         opcode,
	output logic [NBOPER-1:0]        operand
);
	import cpu_pkg::*;

	logic              started;
	logic              jump;
	logic              call;
	logic              ret;
	logic              load;
	logic [MINSTW-1:0] pc_addr;
	logic [MINSTW-1:0] ret_addr;
	logic [MINSTW-1:0] target;

	// Word answering the reset-time address arrives one cycle later
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			started <= 1'b0;
		end else begin
			started <= 1'b1;
		end
	end

	// Word read during reset is not a real instruction
	assign opcode  = started ? opcode_e'(instr[NBOPCO+NBOPER-1:NBOPER]) : OP_NOP;
	assign operand = instr[NBOPER-1:0];

	// Branches resolve here ------------------------
	// JIZ taken on an even accumulator
	assign jump = (opcode == OP_JMP) || ((opcode == OP_JIZ) && !acc_lsb);
	assign call = (opcode == OP_CAL);
	assign ret  = (opcode == OP_RET);
	assign load = jump || call || ret;

	assign target     = ret ? ret_addr : operand[MINSTW-1:0];
	assign instr_addr = load ? target : pc_addr;

	program_counter #(
		.MINSTW(MINSTW)
	) u_pc (
		.clk   (clk),
		.rst   (rst),
		.load  (load),
		.target(target),
		.addr  (pc_addr)
	);

	// Counter already points past the CAL, so that is the return address
	lifo_stack #(
		.WIDTH(MINSTW),
		.DEPTH(SDEPTH)
	) u_call_stack (
		.clk (clk),
		.rst (rst),
		.push(call),
		.pop (ret),
		.din (pc_addr),
		.top (ret_addr)
	);

endmodule

/* alu.sv */
// Integer ALU
// Arithmetic, logic, shift and compare, accumulator as first operand

module alu #(
	parameter int NUBITS = cpu_pkg::NUBITS
) (
	input  cpu_pkg::alu_op_e  op,
	input  logic [NUBITS-1:0] in1,
	input  logic [NUBITS-1:0] acc,
	output logic [NUBITS-1:0] result
);
	import cpu_pkg::*;

	logic [3:0] shamt;
	logic       less;
	logic       equal;

	assign shamt = in1[3:0];
	assign less  = $signed(acc) < $signed(in1);
	assign equal = (acc == in1);

	always_comb begin
		case (op)
			ALU_PASS_ACC: result = acc;
			ALU_PASS_IN:  result = in1;
			ALU_ADD:      result = acc + in1;
			ALU_SUB:      result = acc - in1;
			ALU_AND:      result = acc & in1;
			ALU_OR:       result = acc | in1;
			ALU_XOR:      result = acc ^ in1;
			ALU_SHL:      result = acc << shamt;
			ALU_SHR:      result = acc >> shamt;
			// Compares yield 0 or 1
			ALU_LES:      result = {{(NUBITS-1){1'b0}}, less};
			ALU_EQU:      result = {{(NUBITS-1){1'b0}}, equal};
			ALU_NOT:      result = ~acc;
			default:      result = acc;
		endcase
	end

endmodule

/* lifo_stack.sv */
// Push/pop stack with a combinational top of stack
// Serves as both the call stack and the data stack

module lifo_stack #(
	parameter int WIDTH = cpu_pkg::NUBITS,
	parameter int DEPTH = cpu_pkg::DDEPTH
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] top
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    ptr;
	logic [AW-1:0]    ptr_dec;

	// ptr points at the next free slot
	assign ptr_dec = ptr - 1'b1;
	assign top     = mem[ptr_dec];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr_dec;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

endmodule

/* program_counter.sv */
// Instruction address counter
// Steps by one each cycle, or continues from a loaded branch target

module program_counter #(
	parameter int MINSTW = cpu_pkg::MINSTW
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              load,
	input  logic [MINSTW-1:0] target,
	output logic [MINSTW-1:0] addr
);

	logic [MINSTW-1:0] base;

	// Address presented this cycle, counter holds the one after it
	assign base = load ? target : addr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			addr <= '0;
		end else begin
			addr <= base + 1'b1;
		end
	end

endmodule

/* cpu_pkg.sv */
// Shared definitions for the accumulator/stack processor core
// Opcodes, ALU functions, execute controls and default widths

package cpu_pkg;

	// Default widths -----------------------------
	parameter int NBOPCO = 7;
	parameter int NBOPER = 9;
	parameter int MINSTW = 9;
	parameter int MDATAW = 9;
	parameter int NUBITS = 16;
	parameter int SDEPTH = 8;
	parameter int DDEPTH = 8;
	parameter int NBIO   = 2;

	// Instruction set ----------------------------
	typedef enum logic [6:0] {
		OP_NOP = 7'd0,
		OP_LOD = 7'd1,
		OP_SET = 7'd2,
		OP_PSH = 7'd3,
		OP_POP = 7'd4,
		OP_INN = 7'd5,
		OP_OUT = 7'd6,
		OP_ADD = 7'd7,
		OP_SUB = 7'd8,
		OP_AND = 7'd9,
		OP_ORR = 7'd10,
		OP_XOR = 7'd11,
		OP_SHL = 7'd12,
		OP_SHR = 7'd13,
		OP_LES = 7'd14,
		OP_JMP = 7'd15,
		OP_JIZ = 7'd16,
		OP_CAL = 7'd17,
		OP_RET = 7'd18,
		OP_EQU = 7'd19,
		OP_INV = 7'd20
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_PASS_ACC,
		ALU_PASS_IN,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_LES,
		ALU_EQU,
		ALU_NOT
	} alu_op_e;

	// Where the execute operand comes from
	typedef enum logic [1:0] {
		SRC_MEM,
		SRC_STACK,
		SRC_IO
	} src_e;

	// Structs ------------------------------------
	typedef struct packed {
		alu_op_e           alu_op;
		src_e              src;
		logic              mem_we;
		logic              push;
		logic              pop;
		logic              out_en;
		logic [NBOPER-1:0] addr;
	} exec_ctrl_t;

	typedef struct packed {
		logic              en;
		logic [MDATAW-1:0] addr;
		logic [NUBITS-1:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic              en;
		logic [NBIO-1:0]   addr;
		logic [NUBITS-1:0] data;
	} io_out_t;

endpackage
